/* rtl/sys1_ctrl_pkg.sv */
/*
  Shared types and constants for the System-1 player-control path.
  Games and key actions are enums; all widths and codes live here.
  Direction nibbles are ordered up, down, left, right from bit 3 to bit 0
  for both the keyboard and the joystick.
*/

package sys1_ctrl_pkg;

	// ############################################################
	// Enumerations
	// ############################################################

	// Cabinet variants that need their own control mapping
	typedef enum logic [2:0]
	{
		game_marble,
		game_indy,
		game_peterpak,
		game_roadrun,
		game_roadblast
	} game_t;

	// What a keyboard scan code does once classified
	typedef enum logic [3:0]
	{
		act_none,
		act_up,
		act_down,
		act_left,
		act_right,
		act_button0,
		act_button1,
		act_coin_l,
		act_coin_r,
		act_coin_aux
	} key_action_t;

	// ############################################################
	// Download channel
	// ############################################################

	// Game byte values as sent by the loader
	localparam logic [7:0] GAME_CODE_MARBLE      = 8'd103;
	localparam logic [7:0] GAME_CODE_INDY        = 8'd105;
	localparam logic [7:0] GAME_CODE_PETERPAK    = 8'd107;
	localparam logic [7:0] GAME_CODE_ROADRUN     = 8'd108;
	// Two Roadblasters revisions, same controls
	localparam logic [7:0] GAME_CODE_ROADBLAST_A = 8'd109;
	localparam logic [7:0] GAME_CODE_ROADBLAST_B = 8'd110;

	// Index on which the game byte arrives
	localparam logic [7:0] DL_INDEX_GAME_TYPE = 8'd1;

	// ############################################################
	// PS/2 scan codes, bit 8 is the extended (E0) flag
	// ############################################################

	localparam logic [8:0] KEY_UP       = 9'h175;
	localparam logic [8:0] KEY_DOWN     = 9'h172;
	localparam logic [8:0] KEY_LEFT     = 9'h16B;
	localparam logic [8:0] KEY_RIGHT    = 9'h174;
	// Left ctrl and left alt
	localparam logic [8:0] KEY_BUTTON1  = 9'h014;
	localparam logic [8:0] KEY_BUTTON0  = 9'h011;
	// Digit keys 5, 6 and 7
	localparam logic [8:0] KEY_COIN_L   = 9'h02E;
	localparam logic [8:0] KEY_COIN_R   = 9'h036;
	localparam logic [8:0] KEY_COIN_AUX = 9'h03D;

	// ADC levels, pots idle at mid scale
	localparam logic [7:0] ADC_CENTER = 8'h80;
	localparam logic [7:0] ADC_FULL   = 8'hFF;
	localparam logic [7:0] ADC_ZERO   = 8'h00;

	// Port widths
	localparam int DIR_W      = 8;
	localparam int SW_W       = 5;
	localparam int COIN_W     = 3;
	localparam int ADC_ADDR_W = 3;
	localparam int ADC_W      = 8;
	localparam int JOY_BTN_W  = 9;
	localparam int JOY_AXIS_W = 16;

endpackage

/* rtl/key_decoder.sv */
/*
  PS/2 key event decoder. ps2_key bit 10 toggles once per event.
  The event word is staged one clock before the toggle compare, so a
  held key changes on the edge after the event is first sampled.
  A spurious event can follow reset if the toggle bit idles high.
*/

`timescale 1ns/100ps

module key_decoder import sys1_ctrl_pkg::*;
(
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic [10:0] ps2_key,
	// Up, down, left, right from bit 3 down
	output logic [3:0]  key_dirs,
	// Bit 0 left alt, bit 1 left ctrl
	output logic [1:0]  key_buttons,
	// Aux, right, left from bit 2 down
	output logic [2:0]  key_coins
);

	logic        evt_toggle_q;
	logic        evt_toggle_prev;
	logic        evt_pressed_q;
	logic [8:0]  evt_code_q;
	logic        evt_new;
	key_action_t evt_action;

	// ############################################################
	// Event capture
	// ############################################################

	// Toggle history
	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			evt_toggle_q    <= 1'b0;
			evt_toggle_prev <= 1'b0;
		end
		else
		begin
			evt_toggle_q    <= ps2_key[10];
			evt_toggle_prev <= evt_toggle_q;
		end
	end

	// Code and press flag ride along with the toggle
	always_ff @(posedge clk_sys)
	begin
		evt_pressed_q <= ps2_key[9];
		evt_code_q    <= ps2_key[8:0];
	end

	// New event whenever the staged toggle moved
	assign evt_new = evt_toggle_q ^ evt_toggle_prev;

	// ############################################################
	// Classification and held state
	// ############################################################

	always_comb
	begin
		case (evt_code_q)
			KEY_UP:       evt_action = act_up;
			KEY_DOWN:     evt_action = act_down;
			KEY_LEFT:     evt_action = act_left;
			KEY_RIGHT:    evt_action = act_right;
			KEY_BUTTON0:  evt_action = act_button0;
			KEY_BUTTON1:  evt_action = act_button1;
			KEY_COIN_L:   evt_action = act_coin_l;
			KEY_COIN_R:   evt_action = act_coin_r;
			KEY_COIN_AUX: evt_action = act_coin_aux;
			// Anything else is ignored
			default:      evt_action = act_none;
		endcase
	end

	// Only the matching action follows the press flag
	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			key_dirs    <= 4'b0000;
			key_buttons <= 2'b00;
			key_coins   <= 3'b000;
		end
		else if (evt_new)
		begin
			case (evt_action)
				act_up:       key_dirs[3]    <= evt_pressed_q;
				act_down:     key_dirs[2]    <= evt_pressed_q;
				act_left:     key_dirs[1]    <= evt_pressed_q;
				act_right:    key_dirs[0]    <= evt_pressed_q;
				act_button0:  key_buttons[0] <= evt_pressed_q;
				act_button1:  key_buttons[1] <= evt_pressed_q;
				act_coin_l:   key_coins[0]   <= evt_pressed_q;
				act_coin_r:   key_coins[1]   <= evt_pressed_q;
				act_coin_aux: key_coins[2]   <= evt_pressed_q;
				default:      key_dirs       <= key_dirs;
			endcase
		end
	end

endmodule

/* rtl/control_mapper.sv */
/*
  Game-specific mapping of keyboard, joystick and mouse onto the cabinet
  direction inputs, switch bank and coin lines. Switches and coins are
  active low. Joystick bits 6 and 7 have no use here.
  Game select defaults to Indy and ignores unknown codes.
*/

`timescale 1ns/100ps

module control_mapper import sys1_ctrl_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 arst_n,
	input  logic [3:0]           key_dirs,
	input  logic [1:0]           key_buttons,
	input  logic [2:0]           key_coins,
	input  logic [JOY_BTN_W-1:0] joy_buttons,
	input  logic [1:0]           mouse_buttons,
	input  logic                 mouse_swap,
	input  logic                 service,
	input  logic                 dl_wr,
	input  logic [7:0]           dl_index,
	input  logic [7:0]           dl_data,
	output game_t                game,
	output logic [DIR_W-1:0]     player_dirs,
	output logic [SW_W-1:0]      switches,
	output logic [COIN_W-1:0]    coin_n,
	output logic                 selftest_n
);

	logic              dir_u;
	logic              dir_d;
	logic              dir_l;
	logic              dir_r;
	logic [1:0]        mouse_merged;
	logic              btn0;
	logic              btn1;
	logic [DIR_W-1:0]  dirs_next;
	logic [SW_W-1:0]   sw_next;

	// ############################################################
	// Game register from the download channel
	// ############################################################

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
			game <= game_indy;
		else if (dl_wr && (dl_index == DL_INDEX_GAME_TYPE))
		begin
			case (dl_data)
				GAME_CODE_MARBLE:      game <= game_marble;
				GAME_CODE_INDY:        game <= game_indy;
				GAME_CODE_PETERPAK:    game <= game_peterpak;
				GAME_CODE_ROADRUN:     game <= game_roadrun;
				GAME_CODE_ROADBLAST_A,
				GAME_CODE_ROADBLAST_B: game <= game_roadblast;
				// Unknown byte keeps the current game
				default:               game <= game;
			endcase
		end
	end

	// ############################################################
	// Input merge
	// ############################################################

	// Keyboard OR joystick per direction
	assign dir_u = key_dirs[3] | joy_buttons[3];
	assign dir_d = key_dirs[2] | joy_buttons[2];
	assign dir_l = key_dirs[1] | joy_buttons[1];
	assign dir_r = key_dirs[0] | joy_buttons[0];

	// Mouse order per switch bit, crossed on swap
	assign mouse_merged = mouse_swap ? {mouse_buttons[0], mouse_buttons[1]} : mouse_buttons;

	always_comb
	begin
		btn0 = key_buttons[0] | joy_buttons[4];
		btn1 = key_buttons[1] | joy_buttons[5];
		// Trackball games also take the mouse buttons
		if ((game == game_marble) || (game == game_roadblast))
		begin
			btn0 = btn0 | mouse_merged[1];
			btn1 = btn1 | mouse_merged[0];
		end

		dirs_next = '0;
		sw_next   = {3'b111, ~btn0, ~btn1};
		case (game)
			// Shifted up by one, 000UDLR0
			game_indy:      dirs_next[4:1] = {dir_u, dir_d, dir_l, dir_r};
			game_peterpak:
			begin
				dirs_next[3:0] = {dir_u, dir_d, dir_l, dir_r};
				// Jump on SW3, throw on SW1
				sw_next        = {2'b11, ~btn0, 1'b1, ~btn1};
			end
			game_roadrun:   dirs_next[3:0] = {dir_u, dir_d, dir_l, dir_r};
			// Joystick only, bit order reversed
			game_roadblast: dirs_next[3:0] = {joy_buttons[0], joy_buttons[1],
				joy_buttons[2], joy_buttons[3]};
			// Trackball sits 45 degrees clockwise
			game_marble:    dirs_next[3:0] = {dir_u | dir_r, dir_d | dir_l,
				dir_l | dir_u, dir_r | dir_d};
			default:        dirs_next = '0;
		endcase
	end

	// ############################################################
	// Output registers
	// ############################################################

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			player_dirs <= '0;
			switches    <= '1;
			coin_n      <= '1;
			selftest_n  <= 1'b1;
		end
		else
		begin
			player_dirs <= dirs_next;
			switches    <= sw_next;
			// Aux, right, left; joystick coin shares the left chute
			coin_n      <= {~key_coins[2], ~key_coins[1], ~(key_coins[0] | joy_buttons[8])};
			selftest_n  <= ~service;
		end
	end

endmodule

/* rtl/adc_responder.sv */
/*
  ADC channel answer for the addressed channel, one clock after the
  address. Joystick axes are signed bytes, Y in the high byte.
  Marble uses trackball quadrature instead, so its channels sit at
  mid scale.
*/

`timescale 1ns/100ps

module adc_responder import sys1_ctrl_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  game_t                 game,
	input  logic [DIR_W-1:0]      player_dirs,
	input  logic [JOY_AXIS_W-1:0] joy_axis,
	input  logic [ADC_ADDR_W-1:0] adc_addr,
	output logic [ADC_W-1:0]      adc_data
);

	logic [7:0]       axis_x;
	logic [7:0]       axis_y;
	logic             dir_sel;
	logic [ADC_W-1:0] adc_next;

	assign axis_x = joy_axis[7:0];
	assign axis_y = joy_axis[15:8];

	// Direction bit picked by the channel address
	assign dir_sel = player_dirs[adc_addr];

	// ############################################################
	// Per-game channel value
	// ############################################################

	always_comb
	begin
		adc_next = ADC_CENTER;
		case (game)
			// On/off switch style, full or idle
			game_indy,
			game_peterpak:
				adc_next = dir_sel ? ADC_FULL : ADC_CENTER;

			game_roadrun:
			begin
				// Signed to unsigned, range flipped
				// Left FF, right 00
				if (adc_addr == 3'd0)
					adc_next = axis_x ^ 8'h7F;
				// Signed to unsigned, down FF
				else if (adc_addr == 3'd7)
					adc_next = axis_y ^ 8'h80;
				else
					adc_next = ADC_CENTER;
			end

			game_roadblast:
			begin
				// Throttle from pushing the stick up only
				// Magnitude inverted and doubled, low bit set
				if ((adc_addr == 3'd3) && axis_y[7])
					adc_next = {~axis_y[6:0], 1'b1};
				else
					adc_next = ADC_ZERO;
			end

			game_marble:
				adc_next = ADC_CENTER;

			default:
				adc_next = ADC_CENTER;
		endcase
	end

	// ############################################################
	// Output register
	// ############################################################

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
			adc_data <= ADC_CENTER;
		else
			adc_data <= adc_next;
	end

endmodule

/* rtl/sys1_controls.sv */
/*
  Player-control path of the System-1 cabinet port.
  Keyboard events reach the outputs two clocks after sampling,
  joystick, mouse and service one clock, game writes two clocks.
*/

`timescale 1ns/100ps

module sys1_controls import sys1_ctrl_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  arst_n,
	// Toggle, pressed, extended flag and code
	input  logic [10:0]           ps2_key,
	input  logic [JOY_BTN_W-1:0]  joy_buttons,
	input  logic [JOY_AXIS_W-1:0] joy_axis,
	input  logic [1:0]            mouse_buttons,
	input  logic                  mouse_swap,
	input  logic                  service,
	// Download channel
	input  logic                  dl_wr,
	input  logic [7:0]            dl_index,
	input  logic [7:0]            dl_data,
	input  logic [ADC_ADDR_W-1:0] adc_addr,
	output logic [DIR_W-1:0]      player_dirs,
	output logic [SW_W-1:0]       switches,
	output logic [COIN_W-1:0]     coin_n,
	output logic                  selftest_n,
	output logic [ADC_W-1:0]      adc_data
);

	logic [3:0] key_dirs;
	logic [1:0] key_buttons;
	logic [2:0] key_coins;
	game_t      game;

	// Keyboard held state
	key_decoder u_key_decoder
	(
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.ps2_key     (ps2_key),
		.key_dirs    (key_dirs),
		.key_buttons (key_buttons),
		.key_coins   (key_coins)
	);

	// Game select and cabinet inputs
	control_mapper u_control_mapper
	(
		.clk_sys       (clk_sys),
		.arst_n        (arst_n),
		.key_dirs      (key_dirs),
		.key_buttons   (key_buttons),
		.key_coins     (key_coins),
		.joy_buttons   (joy_buttons),
		.mouse_buttons (mouse_buttons),
		.mouse_swap    (mouse_swap),
		.service       (service),
		.dl_wr         (dl_wr),
		.dl_index      (dl_index),
		.dl_data       (dl_data),
		.game          (game),
		.player_dirs   (player_dirs),
		.switches      (switches),
		.coin_n        (coin_n),
		.selftest_n    (selftest_n)
	);

	// Analog channels, fed from the registered directions
	adc_responder u_adc_responder
	(
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.game        (game),
		.player_dirs (player_dirs),
		.joy_axis    (joy_axis),
		.adc_addr    (adc_addr),
		.adc_data    (adc_data)
	);

endmodule

/* bench/sys1_controls_properties.sv */
/*
  Concurrent checks bound into the control top level.
  Only active while arst_n is high.
*/

`timescale 1ns/100ps

module sys1_controls_properties import sys1_ctrl_pkg::*;
(
	input logic            clk_sys,
	input logic            arst_n,
	input logic [10:0]     ps2_key,
	input logic [8:0]      held_keys,
	input game_t           game,
	input logic [SW_W-1:0] switches,
	input logic [ADC_W-1:0] adc_data
);

	// Count of failed assertions
	int assert_failures = 0;

	// Switch bits 4 and 3 are never mapped
	assert property (@(posedge clk_sys) disable iff (!arst_n) switches[4:3] == 2'b11)
	else
	begin
		assert_failures++;
		$error("switch bits 4:3 left one");
	end

	// Held keys move two samples after a toggle change only
	assert property (@(posedge clk_sys) disable iff (!arst_n)
		$changed(held_keys) |-> ($past(ps2_key[10], 2) != $past(ps2_key[10], 3)))
	else
	begin
		assert_failures++;
		$error("held keys changed without a toggle event");
	end

	// adc_data lags the game by one clock
	assert property (@(posedge clk_sys) disable iff (!arst_n)
		($past(game) == game_marble) |-> (adc_data == ADC_CENTER))
	else
	begin
		assert_failures++;
		$error("adc_data left center in marble");
	end

endmodule

bind sys1_controls sys1_controls_properties u_sys1_controls_properties
(
	.clk_sys   (clk_sys),
	.arst_n    (arst_n),
	.ps2_key   (ps2_key),
	.held_keys ({key_dirs, key_buttons, key_coins}),
	.game      (game),
	.switches  (switches),
	.adc_data  (adc_data)
);

/* bench/tb_sys1_controls.sv */
/*
  Directed testbench for the control path. Inputs change on falling edges,
  outputs are checked on falling edges. Axis values come from $urandom.
*/

`timescale 1ns/100ps

module tb_sys1_controls import sys1_ctrl_pkg::*;
();

	// Well above the length of all directed tests
	localparam int WATCHDOG_CYCLES = 2000;

	logic clk_sys;
	logic arst_n;
	logic [10:0] ps2_key;
	logic [JOY_BTN_W-1:0] joy_buttons;
	logic [JOY_AXIS_W-1:0] joy_axis;
	logic [1:0] mouse_buttons;
	logic mouse_swap;
	logic service;
	logic dl_wr;
	logic [7:0] dl_index;
	logic [7:0] dl_data;
	logic [ADC_ADDR_W-1:0] adc_addr;
	logic [DIR_W-1:0] player_dirs;
	logic [SW_W-1:0] switches;
	logic [COIN_W-1:0] coin_n;
	logic selftest_n;
	logic [ADC_W-1:0] adc_data;
	logic key_toggle;
	int n_tests;
	int n_checks;
	int n_errors;

	sys1_controls u_sys1_controls (.*);

	initial
	begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ############################################################
	// Helpers and compare tasks
	// ############################################################

	task automatic step(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic mismatch(input string msg);
		n_errors++;
		$display("MISMATCH at %0t: %s", $time, msg);
	endtask

	task automatic check_byte(input logic [ADC_W-1:0] got, input logic [ADC_W-1:0] exp,
		input string what);
		n_checks++;
		if (got !== exp)
			mismatch($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic check_sw(input logic [SW_W-1:0] exp, input string what);
		n_checks++;
		if (switches !== exp)
			mismatch($sformatf("%s switches %b expected %b", what, switches, exp));
	endtask

	task automatic check_coin(input logic [COIN_W-1:0] exp, input logic exp_st, input string what);
		n_checks++;
		if ({coin_n, selftest_n} !== {exp, exp_st})
			mismatch($sformatf("%s coin_n/selftest_n %b/%b expected %b/%b", what,
				coin_n, selftest_n, exp, exp_st));
	endtask

	// New toggle value, then wait until the key reaches the outputs
	task automatic send_key(input logic [8:0] code, input logic pressed);
		key_toggle = ~key_toggle;
		ps2_key = {key_toggle, pressed, code};
		step(3);
	endtask

	// One-clock write strobe, mapping visible after the second edge
	task automatic write_dl(input logic [7:0] index, input logic [7:0] data);
		dl_wr = 1'b1;
		dl_index = index;
		dl_data = data;
		step(1);
		dl_wr = 1'b0;
		step(1);
	endtask

	task automatic read_adc(input logic [ADC_ADDR_W-1:0] addr, input logic [ADC_W-1:0] exp,
		input string what);
		adc_addr = addr;
		step(1);
		check_byte(adc_data, exp, $sformatf("%s ch%0d", what, addr));
	endtask

	task automatic report_test(input string name, input int errs_before);
		n_tests++;
		$display("Test %s finished, %0d errors", name, n_errors - errs_before);
	endtask

	// ############################################################
	// Directed tests
	// ############################################################

	task automatic test_reset();
		int errs;
		errs = n_errors;
		check_byte(player_dirs, 8'h00, "reset player_dirs");
		check_sw(5'b11111, "reset");
		check_coin(3'b111, 1'b1, "reset");
		check_byte(adc_data, ADC_CENTER, "reset adc_data");
		// Indy by default, up lands on bit 4
		joy_buttons = 9'h008;
		step(1);
		check_byte(player_dirs, 8'h10, "indy joystick up");
		joy_buttons = '0;
		step(1);
		report_test("reset", errs);
	endtask

	task automatic test_keys();
		int errs;
		errs = n_errors;
		send_key(KEY_UP, 1'b1);
		check_byte(player_dirs, 8'h10, "key up press");
		// Press flag drops but toggle stays
		ps2_key[9] = 1'b0;
		step(3);
		check_byte(player_dirs, 8'h10, "no toggle change");
		send_key(KEY_UP, 1'b0);
		check_byte(player_dirs, 8'h00, "key up release");
		send_key(9'h01C, 1'b1);
		check_byte(player_dirs, 8'h00, "unlisted code");
		check_sw(5'b11111, "unlisted code");
		check_coin(3'b111, 1'b1, "unlisted code");
		send_key(KEY_LEFT, 1'b1);
		check_byte(player_dirs, 8'h04, "key left press");
		send_key(KEY_LEFT, 1'b0);
		send_key(KEY_BUTTON0, 1'b1);
		check_sw(5'b11101, "key button0 indy");
		send_key(KEY_BUTTON0, 1'b0);
		check_sw(5'b11111, "key button0 release");
		report_test("keys", errs);
	endtask

	task automatic test_game();
		int errs;
		errs = n_errors;
		write_dl(DL_INDEX_GAME_TYPE, GAME_CODE_PETERPAK);
		joy_buttons = 9'h018;
		step(1);
		check_byte(player_dirs, 8'h08, "peterpak up");
		check_sw(5'b11011, "peterpak button0");
		write_dl(8'd2, GAME_CODE_ROADRUN);
		check_byte(player_dirs, 8'h08, "wrong index");
		check_sw(5'b11011, "wrong index");
		write_dl(DL_INDEX_GAME_TYPE, 8'd200);
		check_byte(player_dirs, 8'h08, "unknown code");
		check_sw(5'b11011, "unknown code");
		joy_buttons = '0;
		step(1);
		report_test("game", errs);
	endtask

	task automatic test_adc();
		int errs;
		logic [15:0] axis;
		errs = n_errors;
		// Peterpak down is player_dirs bit 2
		joy_buttons = 9'h004;
		step(1);
		read_adc(3'd2, ADC_FULL, "peterpak");
		read_adc(3'd3, ADC_CENTER, "peterpak");
		write_dl(DL_INDEX_GAME_TYPE, GAME_CODE_INDY);
		read_adc(3'd3, ADC_FULL, "indy");
		read_adc(3'd2, ADC_CENTER, "indy");
		joy_buttons = '0;
		write_dl(DL_INDEX_GAME_TYPE, GAME_CODE_ROADRUN);
		repeat (4)
		begin
			axis = $urandom;
			joy_axis = axis;
			read_adc(3'd0, {axis[7], ~axis[6:0]}, "roadrun x");
			read_adc(3'd7, {~axis[15], axis[14:8]}, "roadrun y");
			read_adc(3'd5, ADC_CENTER, "roadrun idle");
		end
		report_test("adc", errs);
	endtask

	task automatic test_roadblast_marble();
		int errs;
		logic [15:0] axis;
		errs = n_errors;
		write_dl(DL_INDEX_GAME_TYPE, GAME_CODE_ROADBLAST_B);
		joy_buttons = 9'h001;
		step(1);
		check_byte(player_dirs, 8'h08, "roadblast reversed");
		joy_buttons = '0;
		send_key(KEY_UP, 1'b1);
		check_byte(player_dirs, 8'h00, "roadblast ignores keys");
		send_key(KEY_UP, 1'b0);
		repeat (3)
		begin
			axis = $urandom;
			axis[15] = 1'b1;
			joy_axis = axis;
			read_adc(3'd3, {~axis[14:8], 1'b1}, "throttle");
			read_adc(3'd2, ADC_ZERO, "roadblast other");
			joy_axis[15] = 1'b0;
			read_adc(3'd3, ADC_ZERO, "throttle y positive");
		end
		mouse_buttons = 2'b01;
		step(1);
		check_sw(5'b11110, "roadblast mouse");
		mouse_swap = 1'b1;
		step(1);
		check_sw(5'b11101, "roadblast mouse swapped");
		mouse_swap = 1'b0;
		mouse_buttons = 2'b00;
		write_dl(DL_INDEX_GAME_TYPE, GAME_CODE_MARBLE);
		// Up alone covers two diagonals
		joy_buttons = 9'h008;
		step(1);
		check_byte(player_dirs, 8'h0A, "marble up");
		joy_buttons = 9'h001;
		step(1);
		check_byte(player_dirs, 8'h09, "marble right");
		read_adc(3'd3, ADC_CENTER, "marble");
		joy_buttons = '0;
		mouse_buttons = 2'b10;
		step(1);
		check_sw(5'b11101, "marble mouse");
		mouse_swap = 1'b1;
		step(1);
		check_sw(5'b11110, "marble mouse swapped");
		mouse_swap = 1'b0;
		mouse_buttons = 2'b00;
		step(1);
		report_test("roadblast_marble", errs);
	endtask

	task automatic test_coins();
		int errs;
		errs = n_errors;
		write_dl(DL_INDEX_GAME_TYPE, GAME_CODE_INDY);
		mouse_buttons = 2'b11;
		step(1);
		check_sw(5'b11111, "indy ignores mouse");
		mouse_buttons = 2'b00;
		send_key(KEY_COIN_L, 1'b1);
		check_coin(3'b110, 1'b1, "coin left key");
		send_key(KEY_COIN_L, 1'b0);
		send_key(KEY_COIN_R, 1'b1);
		check_coin(3'b101, 1'b1, "coin right key");
		send_key(KEY_COIN_R, 1'b0);
		send_key(KEY_COIN_AUX, 1'b1);
		check_coin(3'b011, 1'b1, "coin aux key");
		send_key(KEY_COIN_AUX, 1'b0);
		joy_buttons = 9'h100;
		service = 1'b1;
		step(1);
		check_coin(3'b110, 1'b0, "joystick coin and service");
		joy_buttons = '0;
		service = 1'b0;
		step(1);
		check_coin(3'b111, 1'b1, "coins released");
		report_test("coins", errs);
	endtask

	// ############################################################
	// Main sequence and watchdog
	// ############################################################

	initial
	begin
		void'($urandom(32'h50e66aac));
		{arst_n, ps2_key, joy_buttons, joy_axis, mouse_buttons} = '0;
		{mouse_swap, service, dl_wr, dl_index, dl_data, adc_addr, key_toggle} = '0;
		{n_tests, n_checks, n_errors} = '0;
		repeat (4) @(negedge clk_sys);
		arst_n = 1'b1;
		step(1);
		test_reset();
		test_keys();
		test_game();
		test_adc();
		test_roadblast_marble();
		test_coins();
		n_errors += u_sys1_controls.u_sys1_controls_properties.assert_failures;
		$display("Tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
		if (n_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Something failed");
		$finish;
	end

endmodule

/* sys1_controls.f */
rtl/sys1_ctrl_pkg.sv
rtl/key_decoder.sv
rtl/control_mapper.sv
rtl/adc_responder.sv
rtl/sys1_controls.sv
bench/sys1_controls_properties.sv
bench/tb_sys1_controls.sv
